// File: src/kl_macros.svh
`ifndef KL_MACROS_SVH
`define KL_MACROS_SVH

// Data word and EBUS select widths
`define KL_WORD_BITS 36
`define KL_CS_BITS 7
`define KL_DS_BITS 7

// Physical memory address width, populated words and read latency
`define KL_ADR_BITS 22
`define KL_MEM_WORDS 256
`define KL_MEM_LATENCY 3

// Cycles the front end waits for xfer or in_valid before giving up
`define KL_XFER_TIMEOUT 16

// Controller select that addresses the AR data path
`define KL_EDP_CS 7'o30

`endif

// File: src/ebus_pkg.sv
`default_nettype none

`include "kl_macros.svh"

package ebus_pkg;

  // Diagnostic functions understood by the EDP slices
  typedef enum logic [`KL_DS_BITS-1:0] {
    DS_READ_AR  = 7'o00,
    DS_READ_PAR = 7'o01,
    DS_WRITE_AR = 7'o40
  } diag_fn_e;

  typedef enum logic [1:0] {
    DIAG_WRITE,
    DIAG_READ,
    MEM_WRITE,
    MEM_READ
  } fe_op_e;

  typedef enum logic [2:0] {
    IDLE,
    SETUP,
    STROBE,
    EWAIT,
    MSTART,
    MWAIT,
    DONE
  } fe_state_e;

  typedef struct packed {
    logic                     valid;
    fe_op_e                   op;
    logic [`KL_CS_BITS-1:0]   cs;
    diag_fn_e                 ds;
    logic [`KL_ADR_BITS-1:0]  adr;
    logic [`KL_WORD_BITS-1:0] data;
  } fe_cmd_t;

  typedef struct packed {
    logic                     done;
    logic                     timeout;
    logic [`KL_WORD_BITS-1:0] data;
  } fe_rsp_t;

  // What the front end puts on the backplane toward the slices
  typedef struct packed {
    logic [`KL_CS_BITS-1:0]   cs;
    diag_fn_e                 ds;
    logic                     diag_strobe;
    logic [`KL_WORD_BITS-1:0] data;
  } ebus_t;

  typedef struct packed {
    logic                     driving;
    logic [`KL_WORD_BITS-1:0] data;
  } ebus_driver_t;

endpackage

`default_nettype wire

// File: src/mbus_pkg.sv
`default_nettype none

`include "kl_macros.svh"

package mbus_pkg;

  // Requester side of one MBUS cycle
  typedef struct packed {
    logic                     start;
    logic                     wr_rq;
    logic                     rd_rq;
    logic [`KL_ADR_BITS-1:0]  adr;
    logic [`KL_WORD_BITS-1:0] d_out;
  } mbus_req_t;

  // Memory side: ackn, then in_valid with the word some cycles later
  typedef struct packed {
    logic                     ackn;
    logic                     in_valid;
    logic [`KL_WORD_BITS-1:0] d_in;
  } mbus_rsp_t;

  typedef enum logic [1:0] {
    M_IDLE,
    M_ACKN,
    M_DELAY
  } mem_state_e;

endpackage

`default_nettype wire

// File: src/xfer_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "kl_macros.svh"

module xfer_timer (
  input  logic clk,
  input  logic arst_n,
  input  logic arm,
  output logic expired
);

  localparam int CW = $clog2(`KL_XFER_TIMEOUT + 1);

  logic [CW-1:0] cnt_q;

  // Count saturates at the limit so expired holds until disarm
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q <= '0;
    end else if (!arm) begin
      cnt_q <= '0;
    end else if (!expired) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // The count still sits at the limit in the first disarmed cycle, arm masks it
  assign expired = arm && (cnt_q == CW'(`KL_XFER_TIMEOUT));

  a_quiet_when_disarmed: assert property (@(posedge clk) disable iff (!arst_n)
    !arm |-> !expired)
    else $error("timer expired while disarmed");

endmodule

`default_nettype wire

// File: src/ebus_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "kl_macros.svh"

module ebus_mux (
  input  ebus_pkg::ebus_driver_t   drv0,
  input  ebus_pkg::ebus_driver_t   drv1,
  input  ebus_pkg::ebus_driver_t   drv2,
  input  ebus_pkg::ebus_driver_t   drv3,
  input  ebus_pkg::ebus_driver_t   drv4,
  input  ebus_pkg::ebus_driver_t   drv5,
  output logic [`KL_WORD_BITS-1:0] data,
  output logic                     xfer
);

  logic edp_driving;

  assign edp_driving = drv0.driving | drv1.driving | drv2.driving |
                       drv3.driving | drv4.driving | drv5.driving;

  // Any slice driving means the whole EDP group is read,
  // each slice contributing only its own six bits
  always_comb begin
    if (edp_driving) begin
      data[5:0]   = drv0.data[5:0];
      data[11:6]  = drv1.data[11:6];
      data[17:12] = drv2.data[17:12];
      data[23:18] = drv3.data[23:18];
      data[29:24] = drv4.data[29:24];
      data[35:30] = drv5.data[35:30];
    end else begin
      data = '0;
    end
  end

  assign xfer = edp_driving;

endmodule

`default_nettype wire

// File: src/edp_slice.sv
`timescale 1ns/1ps
`default_nettype none

`include "kl_macros.svh"

module edp_slice #(
  parameter int SLICE = 0
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  ebus_pkg::ebus_t        ebus,
  output ebus_pkg::ebus_driver_t drv
);
  import ebus_pkg::*;

  localparam int FW  = 6;
  localparam int LSB = SLICE * FW;

  logic [FW-1:0] ar_q;
  logic          sel;
  logic          rd_ar;
  logic          rd_par;

  // Selected only while the front end strobes our controller select
  assign sel    = ebus.diag_strobe && (ebus.cs == `KL_EDP_CS);
  assign rd_ar  = sel && (ebus.ds == DS_READ_AR);
  assign rd_par = sel && (ebus.ds == DS_READ_PAR);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ar_q <= '0;
    end else if (sel && (ebus.ds == DS_WRITE_AR)) begin
      ar_q <= ebus.data[LSB +: FW];
    end
  end

  // Bits outside our field are zero and ignored by the mux anyway
  always_comb begin
    drv.driving = rd_ar || rd_par;
    drv.data    = '0;
    if (rd_ar) begin
      drv.data[LSB +: FW] = ar_q;
    end else if (rd_par) begin
      // Odd parity bit lands in the low bit of the field
      drv.data[LSB] = ~^ar_q;
    end
  end

endmodule

`default_nettype wire

// File: src/mb_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "kl_macros.svh"

module mb_mem (
  input  logic                clk,
  input  logic                arst_n,
  input  mbus_pkg::mbus_req_t req,
  output mbus_pkg::mbus_rsp_t rsp
);
  import mbus_pkg::*;

  localparam int AW = $clog2(`KL_MEM_WORDS);
  localparam int LW = $clog2(`KL_MEM_LATENCY + 1);

  logic [`KL_WORD_BITS-1:0] mem [`KL_MEM_WORDS];

  mem_state_e               state_q;
  logic [LW-1:0]            lat_q;
  logic [AW-1:0]            idx_q;
  logic                     wr_q;
  logic [`KL_WORD_BITS-1:0] dat_q;
  logic                     take;

  // Addresses past the populated words get no ackn at all
  assign take = (state_q == M_IDLE) && req.start && (req.rd_rq || req.wr_rq) &&
                (req.adr < `KL_MEM_WORDS);

  initial begin
    for (int i = 0; i < `KL_MEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= M_IDLE;
      lat_q   <= '0;
    end else begin
      case (state_q)
        M_IDLE: begin
          if (take) begin
            state_q <= M_ACKN;
          end
        end
        M_ACKN: begin
          state_q <= M_DELAY;
          lat_q   <= LW'(1);
        end
        M_DELAY: begin
          if (lat_q == LW'(`KL_MEM_LATENCY)) begin
            state_q <= M_IDLE;
          end else begin
            lat_q <= lat_q + 1'b1;
          end
        end
        default: state_q <= M_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      idx_q <= req.adr[AW-1:0];
      wr_q  <= req.wr_rq;
      dat_q <= req.d_out;
    end
    // Write lands during the ackn cycle, before the data-valid read back
    if ((state_q == M_ACKN) && wr_q) begin
      mem[idx_q] <= dat_q;
    end
  end

  assign rsp.ackn     = (state_q == M_ACKN);
  assign rsp.in_valid = (state_q == M_DELAY) && (lat_q == LW'(`KL_MEM_LATENCY));
  assign rsp.d_in     = rsp.in_valid ? mem[idx_q] : '0;

  a_valid_after_ackn: assert property (@(posedge clk) disable iff (!arst_n)
    rsp.in_valid |-> $past(rsp.ackn, `KL_MEM_LATENCY))
    else $error("in_valid without ackn %0d cycles earlier", `KL_MEM_LATENCY);

endmodule

`default_nettype wire

// File: src/fe_ebus_ctl.sv
`timescale 1ns/1ps
`default_nettype none

`include "kl_macros.svh"

module fe_ebus_ctl (
  input  logic                     clk,
  input  logic                     arst_n,
  input  ebus_pkg::fe_cmd_t        cmd,
  output ebus_pkg::ebus_t          ebus,
  input  logic [`KL_WORD_BITS-1:0] ebus_data,
  input  logic                     xfer,
  output mbus_pkg::mbus_req_t      mreq,
  input  mbus_pkg::mbus_rsp_t      mrsp,
  output logic                     timer_arm,
  input  logic                     timer_expired,
  output ebus_pkg::fe_rsp_t        rsp,
  output logic                     busy
);
  import ebus_pkg::*;

  fe_state_e                state_q;
  fe_state_e                state_d;
  fe_cmd_t                  cmd_q;
  logic                     strobe_q;
  logic                     tmo_q;
  logic                     tmo_d;
  logic [`KL_WORD_BITS-1:0] data_q;
  logic [`KL_WORD_BITS-1:0] data_d;
  logic                     accept;
  logic                     is_diag;

  // Commands arriving while busy are dropped on the floor
  assign accept  = (state_q == IDLE) && cmd.valid;
  assign is_diag = (cmd.op == DIAG_WRITE) || (cmd.op == DIAG_READ);

  always_comb begin
    state_d = state_q;
    data_d  = data_q;
    tmo_d   = tmo_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = is_diag ? SETUP : MSTART;
        end
      end
      SETUP: state_d = STROBE;
      STROBE: begin
        // A write has nobody driving, so the captured word is zero
        if ((cmd_q.op == DIAG_WRITE) || xfer) begin
          state_d = DONE;
          data_d  = ebus_data;
          tmo_d   = 1'b0;
        end else begin
          state_d = EWAIT;
        end
      end
      EWAIT: begin
        if (xfer) begin
          state_d = DONE;
          data_d  = ebus_data;
          tmo_d   = 1'b0;
        end else if (timer_expired) begin
          state_d = DONE;
          data_d  = '0;
          tmo_d   = 1'b1;
        end
      end
      MSTART: state_d = MWAIT;
      MWAIT: begin
        if (mrsp.in_valid) begin
          state_d = DONE;
          data_d  = mrsp.d_in;
          tmo_d   = 1'b0;
        end else if (timer_expired) begin
          state_d = DONE;
          data_d  = '0;
          tmo_d   = 1'b1;
        end
      end
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q  <= IDLE;
      strobe_q <= 1'b0;
      tmo_q    <= 1'b0;
    end else begin
      state_q  <= state_d;
      strobe_q <= (state_q == SETUP);
      tmo_q    <= tmo_d;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd;
    end
    data_q <= data_d;
  end

  // cs, ds and data sit on the bus for the whole operation
  assign ebus.cs          = cmd_q.cs;
  assign ebus.ds          = cmd_q.ds;
  assign ebus.diag_strobe = strobe_q;
  assign ebus.data        = cmd_q.data;

  assign mreq.start = (state_q == MSTART);
  assign mreq.wr_rq = mreq.start && (cmd_q.op == MEM_WRITE);
  assign mreq.rd_rq = mreq.start && (cmd_q.op == MEM_READ);
  assign mreq.adr   = cmd_q.adr;
  assign mreq.d_out = cmd_q.data;

  assign timer_arm = (state_q == EWAIT) || (state_q == MWAIT);

  assign rsp.done    = (state_q == DONE);
  assign rsp.timeout = tmo_q;
  assign rsp.data    = data_q;
  assign busy        = (state_q != IDLE);

  // The strobe flop must stay in step with the FSM
  a_strobe_in_strobe: assert property (@(posedge clk) disable iff (!arst_n)
    ebus.diag_strobe |-> (state_q == STROBE))
    else $error("diag_strobe high outside STROBE");

  a_start_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    mreq.start |=> !mreq.start)
    else $error("MBUS start held longer than one cycle");

endmodule

`default_nettype wire

// File: src/kl_diag_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "kl_macros.svh"

module kl_diag_top (
  input  logic              clk,
  input  logic              arst_n,
  input  ebus_pkg::fe_cmd_t cmd,
  output ebus_pkg::fe_rsp_t rsp,
  output logic              busy
);
  import ebus_pkg::*;
  import mbus_pkg::*;

  localparam int NUM_SLICES = 6;

  ebus_t                    ebus;
  ebus_driver_t             slice_drv [NUM_SLICES];
  logic [`KL_WORD_BITS-1:0] ebus_data;
  logic                     xfer;
  mbus_req_t                mreq;
  mbus_rsp_t                mrsp;
  logic                     timer_arm;
  logic                     timer_expired;

  fe_ebus_ctl i_fe (
    .clk,
    .arst_n,
    .cmd,
    .ebus,
    .ebus_data,
    .xfer,
    .mreq,
    .mrsp,
    .timer_arm,
    .timer_expired,
    .rsp,
    .busy
  );

  xfer_timer i_timer (
    .clk,
    .arst_n,
    .arm     (timer_arm),
    .expired (timer_expired)
  );

  // Slice i holds AR bits 6*i up to 6*i+5
  for (genvar i = 0; i < NUM_SLICES; i++) begin : g_edp
    edp_slice #(.SLICE(i)) i_edp (
      .clk,
      .arst_n,
      .ebus,
      .drv (slice_drv[i])
    );
  end

  ebus_mux i_mux (
    .drv0 (slice_drv[0]),
    .drv1 (slice_drv[1]),
    .drv2 (slice_drv[2]),
    .drv3 (slice_drv[3]),
    .drv4 (slice_drv[4]),
    .drv5 (slice_drv[5]),
    .data (ebus_data),
    .xfer
  );

  mb_mem i_mem (
    .clk,
    .arst_n,
    .req (mreq),
    .rsp (mrsp)
  );

endmodule

`default_nettype wire

// File: verif/kl_diag_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "kl_macros.svh"

module kl_diag_tb;
  import ebus_pkg::*;

  localparam int CYCLES_PER_PATTERN = 40;
  localparam int DIAG_DONE_CYCLES   = 3;

  // One line of the pattern file
  typedef struct packed {
    logic [1:0]               op;
    logic [`KL_CS_BITS-1:0]   cs;
    logic [`KL_DS_BITS-1:0]   ds;
    logic [`KL_ADR_BITS-1:0]  adr;
    logic [`KL_WORD_BITS-1:0] data;
    logic [`KL_WORD_BITS-1:0] exp_data;
    logic                     exp_tmo;
  } pattern_t;

  logic    clk;
  logic    arst_n;
  fe_cmd_t cmd;
  fe_rsp_t rsp;
  logic    busy;

  pattern_t                 pats[$];
  logic [`KL_WORD_BITS-1:0] ref_ar;
  logic [`KL_WORD_BITS-1:0] ref_mem [`KL_MEM_WORDS];
  int                       cycle_count = 0;
  int                       cycle_limit = CYCLES_PER_PATTERN;
  int                       errors;
  int                       failed_tests;

  kl_diag_top i_dut (
    .clk,
    .arst_n,
    .cmd,
    .rsp,
    .busy
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run stalled after %0d cycles before all patterns finished",
               cycle_count);
      $display(">>> FAIL");
      $finish;
    end
  end

  // Odd parity of each 6-bit field, placed in the field's lowest bit
  function automatic logic [`KL_WORD_BITS-1:0] field_parity(
    input logic [`KL_WORD_BITS-1:0] w
  );
    logic [`KL_WORD_BITS-1:0] p;
    p = '0;
    for (int k = 0; k < 6; k++) begin
      p[6*k] = ~^w[6*k +: 6];
    end
    return p;
  endfunction

  task automatic load_patterns;
    int          fd;
    int          n;
    string       line;
    logic [31:0] op_v;
    logic [31:0] cs_v;
    logic [31:0] ds_v;
    logic [31:0] adr_v;
    logic [35:0] data_v;
    logic [35:0] exp_v;
    logic [31:0] tmo_v;
    pattern_t    p;
    fd = $fopen("verif/kl_diag_patterns.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the pattern file verif/kl_diag_patterns.txt");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h",
                  op_v, cs_v, ds_v, adr_v, data_v, exp_v, tmo_v);
      if (n == 7) begin
        p.op       = op_v[1:0];
        p.cs       = cs_v[`KL_CS_BITS-1:0];
        p.ds       = ds_v[`KL_DS_BITS-1:0];
        p.adr      = adr_v[`KL_ADR_BITS-1:0];
        p.data     = data_v;
        p.exp_data = exp_v;
        p.exp_tmo  = tmo_v[0];
        pats.push_back(p);
      end
    end
    $fclose(fd);
  endtask

  // Reference model of the AR and the memory, updated as each pattern runs
  task automatic predict_result(input pattern_t p, output logic [`KL_WORD_BITS-1:0] d,
                                output logic tmo);
    logic edp;
    logic in_range;
    edp      = (p.cs == `KL_EDP_CS);
    in_range = (int'(p.adr) < `KL_MEM_WORDS);
    d        = '0;
    tmo      = 1'b0;
    case (p.op)
      2'd0: begin
        if (edp && (p.ds == DS_WRITE_AR)) begin
          ref_ar = p.data;
        end
      end
      2'd1: begin
        if (edp && (p.ds == DS_READ_AR)) begin
          d = ref_ar;
        end else if (edp && (p.ds == DS_READ_PAR)) begin
          d = field_parity(ref_ar);
        end else begin
          tmo = 1'b1;
        end
      end
      2'd2: begin
        if (in_range) begin
          ref_mem[int'(p.adr)] = p.data;
          d = p.data;
        end else begin
          tmo = 1'b1;
        end
      end
      default: begin
        if (in_range) begin
          d = ref_mem[int'(p.adr)];
        end else begin
          tmo = 1'b1;
        end
      end
    endcase
  endtask

  task automatic run_pattern(input int idx, input pattern_t p);
    logic [`KL_WORD_BITS-1:0] ref_data;
    logic                     ref_tmo;
    int                       lat;
    int                       errs_before;
    logic                     got_done;
    fe_op_e                   op_e;
    errs_before = errors;
    op_e        = fe_op_e'(p.op);
    predict_result(p, ref_data, ref_tmo);
    assert ((ref_data == p.exp_data) && (ref_tmo == p.exp_tmo)) else begin
      $display("Pattern %0d: the expected values in the file disagree with the reference model",
               idx);
      errors++;
    end
    @(posedge clk);
    #1;
    // The previous command has ended, so the controller must be idle here
    assert (!busy) else begin
      $display("MISMATCH at %0t ns: pattern %0d busy high before the command was sent",
               $time, idx);
      errors++;
    end
    cmd.valid = 1'b1;
    cmd.op    = op_e;
    cmd.cs    = p.cs;
    cmd.ds    = diag_fn_e'(p.ds);
    cmd.adr   = p.adr;
    cmd.data  = p.data;
    lat       = 0;
    got_done  = 1'b0;
    while (!got_done) begin
      @(posedge clk);
      #1;
      lat++;
      if (lat == 1) begin
        assert (busy) else begin
          $display("MISMATCH at %0t ns: pattern %0d busy low after the command was sent",
                   $time, idx);
          errors++;
        end
        // A stray AR write while busy, which would corrupt AR if it were taken
        cmd.valid = 1'b1;
        cmd.op    = DIAG_WRITE;
        cmd.cs    = `KL_EDP_CS;
        cmd.ds    = DS_WRITE_AR;
        cmd.adr   = '0;
        cmd.data  = ~p.data;
      end else begin
        cmd = '0;
      end
      got_done = rsp.done;
    end
    assert (rsp.data == p.exp_data) else begin
      $display("MISMATCH at %0t ns: pattern %0d data %h, expected %h",
               $time, idx, rsp.data, p.exp_data);
      errors++;
    end
    assert (rsp.timeout == p.exp_tmo) else begin
      $display("MISMATCH at %0t ns: pattern %0d timeout %b, expected %b",
               $time, idx, rsp.timeout, p.exp_tmo);
      errors++;
    end
    if ((p.op == 2'd0 || p.op == 2'd1) && !p.exp_tmo) begin
      assert (lat == DIAG_DONE_CYCLES) else begin
        $display("MISMATCH at %0t ns: pattern %0d done after %0d cycles, expected %0d",
                 $time, idx, lat, DIAG_DONE_CYCLES);
        errors++;
      end
    end
    if (errors != errs_before) begin
      failed_tests++;
    end
    $display("Test %0d %s cs=%o ds=%o adr=%h: %s", idx, op_e.name(), p.cs, p.ds,
             p.adr, (errors == errs_before) ? "ok" : "FAILED");
  endtask

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    cmd          = '0;
    errors       = 0;
    failed_tests = 0;
    ref_ar       = '0;
    for (int i = 0; i < `KL_MEM_WORDS; i++) begin
      ref_mem[i] = '0;
    end
    load_patterns();
    if (pats.size() == 0) begin
      $display("No patterns were loaded, nothing was tested");
      errors++;
    end
    cycle_limit = CYCLES_PER_PATTERN * (pats.size() + 1);
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;
    foreach (pats[i]) begin
      run_pattern(i, pats[i]);
    end
    $display("Summary: %0d tests, %0d failed, %0d errors", pats.size(), failed_tests, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/kl_diag_patterns.txt
# op cs ds adr data exp_data exp_timeout, all hex
# op 0 diag write, 1 diag read, 2 mem write, 3 mem read; cs 18 is the AR data path
# ds 20 writes AR, 00 reads AR, 01 reads the field parity
1 18 00 000000 000000000 000000000 0
1 18 01 000000 000000000 041041041 0
0 18 20 000000 123456789 000000000 0
1 18 00 000000 000000000 123456789 0
1 18 01 000000 000000000 000040041 0
0 18 20 000000 ABCDEF012 000000000 0
1 18 00 000000 000000000 ABCDEF012 0
1 18 01 000000 000000000 001000041 0
1 05 00 000000 000000000 000000000 1
0 05 20 000000 555555555 000000000 0
1 18 00 000000 000000000 ABCDEF012 0
3 00 00 000010 000000000 000000000 0
2 00 00 000010 0DEADBEEF 0DEADBEEF 0
2 00 00 0000FF 876543210 876543210 0
3 00 00 000010 000000000 0DEADBEEF 0
3 00 00 0000FF 000000000 876543210 0
3 00 00 000011 000000000 000000000 0
2 00 00 000100 111111111 000000000 1
3 00 00 3FFFFF 000000000 000000000 1
3 00 00 000000 000000000 000000000 0
1 18 00 000000 000000000 ABCDEF012 0

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module kl_diag_tb \
  -Mdir obj_dir -o kl_diag_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/kl_diag_sim > sim.log 2>&1 || { cat sim.log; echo "Simulator exited with an error"; exit 1; }
cat sim.log
grep -q '>>> FAIL' sim.log && { echo "Simulation failed"; exit 1; } || { echo "Simulation done"; exit 0; }

// File: project.f
+incdir+src
src/ebus_pkg.sv
src/mbus_pkg.sv
src/xfer_timer.sv
src/ebus_mux.sv
src/edp_slice.sv
src/mb_mem.sv
src/fe_ebus_ctl.sv
src/kl_diag_top.sv
verif/kl_diag_tb.sv
